// ==== Bender.yml ====
package:
  name: rob

sources:
  - target: any(rtl, test)
    files:
      - hw/isa_pkg.sv
      - hw/rob_pkg.sv
      - hw/rob_ctrl.sv
      - hw/rob_wb_match.sv
      - hw/rob_entry_file.sv
      - hw/rob_commit.sv
      - hw/rob_top.sv
  - target: test
    files:
      - verif/rob_chk.sv
      - verif/rob_tb.sv

// ==== filelist.f ====
hw/isa_pkg.sv
hw/rob_pkg.sv
hw/rob_ctrl.sv
hw/rob_wb_match.sv
hw/rob_entry_file.sv
hw/rob_commit.sv
hw/rob_top.sv
verif/rob_chk.sv
verif/rob_tb.sv

// ==== hw/isa_pkg.sv ====
package isa_pkg;

    localparam int XLEN = 32;                 // Data and address width

    // RV32 base instruction word, R-type field view
    typedef struct packed {
        logic [6:0]      funct7;              // Bits 31:25
        logic [4:0]      rs2;                 // Bits 24:20
        logic [4:0]      rs1;                 // Bits 19:15
        logic [2:0]      funct3;              // Bits 14:12
        logic [4:0]      rd;                  // Bits 11:7, destination register
        logic [6:0]      opcode;              // Bits 6:0
    } instr_t;

    // One fetched instruction as seen by the ROB
    typedef struct packed {
        instr_t          instr;               // All zero means bubble
        logic [XLEN-1:0] pc;                  // Fetch PC, also the ROB tag
        logic            reg_write;           // Writes rd on retire
    } fetch_t;

endpackage

// ==== hw/rob_commit.sv ====
`timescale 1ns/1ps

module rob_commit import isa_pkg::*; import rob_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       commit_en,              // Head retires this cycle
    input  rob_entry_t head_entry,
    output commit_t    commit
);

    instr_t          head_instr;               // Field view of stored word
    logic            valid_q;
    logic [XLEN-1:0] value_q;
    logic [4:0]      dest_q;
    logic            rw_q;

    assign head_instr = head_entry.instr;

    // Strobe, one cycle per retirement
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= commit_en;
        end
    end

    // Data held until the next retirement
    always_ff @(posedge clk) begin
        if (commit_en) begin
            value_q <= head_entry.value;
            dest_q  <= head_instr.rd;          // Bits 11:7
            rw_q    <= head_entry.reg_write;
        end
    end

    assign commit = '{valid: valid_q, value: value_q, dest: dest_q, reg_write: rw_q};

endmodule

// ==== hw/rob_ctrl.sv ====
`timescale 1ns/1ps

module rob_ctrl #(
    parameter int  DEPTH = 16,                // Power of two
    localparam int IDX_W = $clog2(DEPTH)
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             fetch_valid,     // Non-bubble word presented
    input  logic             head_valid,
    input  logic             head_ready,
    input  logic             flush,
    input  logic             br_hit,          // Taken branch found in ROB
    input  logic [IDX_W-1:0] br_idx,          // Slot of that branch
    output logic [IDX_W-1:0] head,
    output logic [IDX_W-1:0] tail,
    output logic             alloc_en,
    output logic             commit_en,
    output logic             trunc_en,
    output logic             clear_all,
    output logic             full,
    output logic             empty
);

    logic [IDX_W:0]   count;                  // One extra bit so DEPTH fits
    logic [IDX_W-1:0] br_dist;                // Slots from head to the branch
    logic [IDX_W:0]   keep_cnt;               // Head through branch, inclusive

    assign full  = (count == (IDX_W+1)'(DEPTH));
    assign empty = (count == '0);

    // Flush wins, branch blocks allocation, retire runs alongside a branch
    assign clear_all = flush;
    assign commit_en = !flush && head_valid && head_ready;
    assign trunc_en  = !flush && br_hit;
    assign alloc_en  = !flush && !br_hit && fetch_valid && !full;  // Drop when full

    assign br_dist  = br_idx - head;          // Wraps with the ring
    assign keep_cnt = {1'b0, br_dist} + 1'b1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (clear_all) begin
            head  <= '0;                      // Restart ring at slot 0
            tail  <= '0;
            count <= '0;
        end else begin
            head <= head + IDX_W'(commit_en);
            if (trunc_en) begin
                tail  <= br_idx + 1'b1;       // Next alloc right after branch
                count <= keep_cnt - (IDX_W+1)'(commit_en);
            end else begin
                tail  <= tail + IDX_W'(alloc_en);
                count <= count + (IDX_W+1)'(alloc_en) - (IDX_W+1)'(commit_en);
            end
        end
    end

endmodule

// ==== hw/rob_entry_file.sv ====
`timescale 1ns/1ps

module rob_entry_file import isa_pkg::*; import rob_pkg::*; #(
    parameter int  DEPTH = 16,
    localparam int IDX_W = $clog2(DEPTH)
) (
    input  logic             clk,
    input  logic             rst,
    input  fetch_t           fetch,
    input  logic             alloc_en,
    input  logic             commit_en,
    input  logic             trunc_en,
    input  logic             clear_all,
    input  logic [IDX_W-1:0] head,
    input  logic [IDX_W-1:0] tail,
    input  logic [IDX_W-1:0] br_idx,
    input  logic [DEPTH-1:0] hit,
    input  logic [XLEN-1:0]  hit_value [DEPTH],
    output rob_entry_t       entries [DEPTH],
    output rob_entry_t       head_entry
);

    logic [DEPTH-1:0] valid_q;                 // Slot state, reset
    logic [DEPTH-1:0] ready_q;
    logic             rw_q    [DEPTH];         // Payload, no reset
    logic [XLEN-1:0]  value_q [DEPTH];
    instr_t           instr_q [DEPTH];
    logic [XLEN-1:0]  pc_q    [DEPTH];
    logic [IDX_W-1:0] br_dist;                 // Age of the branch slot
    logic [DEPTH-1:0] younger;                 // Slots behind the branch

    assign br_dist = br_idx - head;

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            younger[i] = (IDX_W'(i) - head) > br_dist;  // Age measured from head
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
            ready_q <= '0;
        end else if (clear_all) begin
            valid_q <= '0;                     // Flush drops everything
            ready_q <= '0;
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                if (alloc_en && tail == IDX_W'(i)) begin
                    valid_q[i] <= 1'b1;        // New slot waits for a result
                    ready_q[i] <= 1'b0;
                end
                if (hit[i]) ready_q[i] <= 1'b1;
                if ((trunc_en && younger[i]) || (commit_en && head == IDX_W'(i))) begin
                    valid_q[i] <= 1'b0;        // Killed or retired
                    ready_q[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (alloc_en && tail == IDX_W'(i)) begin
                rw_q[i]    <= fetch.reg_write;
                value_q[i] <= '0;              // Filled on completion
                instr_q[i] <= fetch.instr;
                pc_q[i]    <= fetch.pc;
            end else if (hit[i]) begin
                value_q[i] <= hit_value[i];    // Result or branch target
            end
        end
    end

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            entries[i] = '{valid: valid_q[i], ready: ready_q[i], reg_write: rw_q[i],
                           value: value_q[i], instr: instr_q[i], pc: pc_q[i]};
        end
    end

    assign head_entry = entries[head];         // Oldest slot to the commit stage

endmodule

// ==== hw/rob_pkg.sv ====
package rob_pkg;

    import isa_pkg::*;

    // One ROB slot, 99 bits
    typedef struct packed {
        logic            valid;               // Slot allocated
        logic            ready;               // Result or target present
        logic            reg_write;           // Writes rd on retire
        logic [XLEN-1:0] value;               // Result, or redirect target
        instr_t          instr;               // Raw instruction word
        logic [XLEN-1:0] pc;                  // Tag for completion lookup
    } rob_entry_t;

    // Completion report from one execution unit
    typedef struct packed {
        logic            done;                // One-cycle strobe
        logic [XLEN-1:0] pc;                  // PC of the finished instruction
        logic [XLEN-1:0] value;               // Computed result
    } wb_t;

    // Resolved taken branch
    typedef struct packed {
        logic            taken;               // One-cycle strobe
        logic [XLEN-1:0] pc;                  // PC of the branch
        logic [XLEN-1:0] target;              // Redirect address
    } br_t;

    // Retirement bundle toward the register file
    typedef struct packed {
        logic            valid;               // One cycle per retired entry
        logic [XLEN-1:0] value;               // Write data
        logic [4:0]      dest;                // rd of the retired instruction
        logic            reg_write;           // Register write enable
    } commit_t;

endpackage

// ==== hw/rob_top.sv ====
`timescale 1ns/1ps

module rob_top import isa_pkg::*; import rob_pkg::*; #(
    parameter int  DEPTH = 16,                 // Entry count, power of two
    localparam int IDX_W = $clog2(DEPTH)
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    flush,                     // Empty the buffer
    input  fetch_t  fetch,
    input  wb_t     alu_wb,
    input  wb_t     mul_wb,
    input  wb_t     div_wb,
    input  br_t     branch,
    output commit_t commit,
    output logic    full,
    output logic    empty
);

    logic [IDX_W-1:0] head, tail, br_idx;
    logic             alloc_en, commit_en, trunc_en, clear_all, br_hit;
    logic [DEPTH-1:0] hit;
    logic [XLEN-1:0]  hit_value [DEPTH];
    rob_entry_t       entries [DEPTH];
    rob_entry_t       head_entry;

    rob_ctrl #(.DEPTH(DEPTH)) i_rob_ctrl (
        .clk, .rst, .flush, .br_hit, .br_idx,
        .fetch_valid (|fetch.instr),           // Zero word is a bubble
        .head_valid  (head_entry.valid),
        .head_ready  (head_entry.ready),
        .head, .tail, .alloc_en, .commit_en, .trunc_en, .clear_all, .full, .empty
    );

    rob_wb_match #(.DEPTH(DEPTH)) i_rob_wb_match (
        .entries, .alu_wb, .mul_wb, .div_wb, .branch,
        .hit, .hit_value, .br_hit, .br_idx
    );

    rob_entry_file #(.DEPTH(DEPTH)) i_rob_entry_file (
        .clk, .rst, .fetch, .alloc_en, .commit_en, .trunc_en, .clear_all,
        .head, .tail, .br_idx, .hit, .hit_value, .entries, .head_entry
    );

    rob_commit i_rob_commit (
        .clk, .rst, .commit_en, .head_entry, .commit
    );

endmodule

// ==== hw/rob_wb_match.sv ====
`timescale 1ns/1ps

module rob_wb_match import isa_pkg::*; import rob_pkg::*; #(
    parameter int  DEPTH = 16,
    localparam int IDX_W = $clog2(DEPTH)
) (
    input  rob_entry_t       entries [DEPTH],  // Current ROB contents
    input  wb_t              alu_wb,
    input  wb_t              mul_wb,
    input  wb_t              div_wb,
    input  br_t              branch,
    output logic [DEPTH-1:0] hit,              // Slot gets ready this cycle
    output logic [XLEN-1:0]  hit_value [DEPTH],// New value per slot
    output logic             br_hit,
    output logic [IDX_W-1:0] br_idx
);

    logic [DEPTH-1:0] alu_m;                   // Per-slot PC compares
    logic [DEPTH-1:0] mul_m;
    logic [DEPTH-1:0] div_m;
    logic [DEPTH-1:0] br_m;

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            alu_m[i] = entries[i].valid && alu_wb.done && (alu_wb.pc == entries[i].pc);
            mul_m[i] = entries[i].valid && mul_wb.done && (mul_wb.pc == entries[i].pc);
            div_m[i] = entries[i].valid && div_wb.done && (div_wb.pc == entries[i].pc);
            br_m[i]  = entries[i].valid && branch.taken && (branch.pc == entries[i].pc);
            // Branch target first, then alu, mul, div
            if (br_m[i]) hit_value[i] = branch.target;
            else if (alu_m[i]) hit_value[i] = alu_wb.value;
            else if (mul_m[i]) hit_value[i] = mul_wb.value;
            else hit_value[i] = div_wb.value;
        end
    end

    assign hit    = alu_m | mul_m | div_m | br_m;  // Unmatched PCs drop out here
    assign br_hit = |br_m;

    // PCs are unique in the ring, so at most one bit is set
    always_comb begin
        br_idx = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (br_m[i]) br_idx = IDX_W'(i);
        end
    end

endmodule

// ==== verif/rob_chk.sv ====
`timescale 1ns/1ps

module rob_chk_props #(
    parameter int  DEPTH = 16,
    localparam int IDX_W = $clog2(DEPTH)
) (
    input logic           clk,
    input logic           rst,
    input logic [IDX_W:0] count,              // Occupancy inside rob_ctrl
    input logic           empty,
    input logic           head_valid,
    input logic           head_ready,
    input logic           alloc_en
);

    int unsigned fails = 0;                   // Failed assertion count

    a_count_bound: assert property (@(posedge clk) disable iff (rst) count <= DEPTH)
        else begin
            fails++;
            $error("ROB occupancy above DEPTH");
        end

    // Head slot valid exactly when the ring holds entries
    a_head_occupancy: assert property (@(posedge clk) disable iff (rst)
        head_valid == !empty)
        else begin
            fails++;
            $error("head slot validity disagrees with occupancy count");
        end

    a_ready_valid: assert property (@(posedge clk) disable iff (rst)
        head_ready |-> head_valid)
        else begin
            fails++;
            $error("head slot ready while not valid");
        end

    a_alloc_fill: assert property (@(posedge clk) disable iff (rst)
        alloc_en |=> !empty)
        else begin
            fails++;
            $error("buffer empty right after an allocation");
        end

endmodule

bind rob_ctrl rob_chk_props #(.DEPTH(DEPTH)) i_rob_chk_props (
    .clk, .rst, .count, .empty, .head_valid, .head_ready, .alloc_en
);

// ==== verif/rob_tb.sv ====
`timescale 1ns/1ps

module rob_tb import isa_pkg::*; import rob_pkg::*; ;

    localparam int DEPTH    = 16;
    localparam int WAIT_MAX = 40;             // Cycles before a commit wait gives up

    logic    clk;
    logic    rst;
    logic    flush;
    fetch_t  fetch;
    wb_t     alu_wb;
    wb_t     mul_wb;
    wb_t     div_wb;
    br_t     branch;
    commit_t commit;
    logic    full;
    logic    empty;

    int unsigned lcg_state = 51;              // Fixed seed
    int          errors;
    int          checks;
    int          test_errors;                 // Error count at test start
    string       test_name;
    commit_t     got_q [$];                   // Commits seen, oldest first

    rob_top #(.DEPTH(DEPTH)) i_rob_top (.*);

    always #50 clk = ~clk;                    // 100 ns period

    function automatic logic [XLEN-1:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [XLEN-1:0] make_instr(input logic [4:0] rd);
        return {7'h00, 5'd2, 5'd1, 3'd0, rd, 7'h33};  // add rd, x1, x2
    endfunction

    task automatic check(input logic [XLEN-1:0] exp, input logic [XLEN-1:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", test_name, exp, act);
        end
    endtask

    // Advance one cycle, land 1 ns after the edge and log any commit
    task automatic tick();
        @(posedge clk);
        #1;
        if (commit.valid) got_q.push_back(commit);
    endtask

    task automatic idle_ports();
        alu_wb = '0;
        mul_wb = '0;
        div_wb = '0;
        branch = '0;
    endtask

    task automatic alloc(input logic [XLEN-1:0] tag, input logic [4:0] rd, input logic rw);
        fetch.instr     = make_instr(rd);
        fetch.pc        = tag;
        fetch.reg_write = rw;
        tick();
        fetch = '0;                           // Back to bubble
    endtask

    // Unit 0 is alu, 1 is mul, anything else div
    task automatic complete(input int unit, input logic [XLEN-1:0] tag,
                            input logic [XLEN-1:0] val);
        case (unit)
            0:       alu_wb = '{done: 1'b1, pc: tag, value: val};
            1:       mul_wb = '{done: 1'b1, pc: tag, value: val};
            default: div_wb = '{done: 1'b1, pc: tag, value: val};
        endcase
        tick();
        idle_ports();
    endtask

    task automatic wait_commit(input logic [XLEN-1:0] val, input logic [4:0] rd,
                               input logic rw);
        commit_t c;
        int      n;
        n = 0;
        while (got_q.size() == 0 && n < WAIT_MAX) begin
            tick();
            n++;
        end
        if (got_q.size() == 0) begin
            errors++;
            $display("%s: no commit arrived within %0d cycles", test_name, WAIT_MAX);
        end else begin
            c = got_q.pop_front();
            check(val, c.value);
            check(XLEN'(rd), XLEN'(c.dest));  // rd field of the word
            check(XLEN'(rw), XLEN'(c.reg_write));
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    // Idle a few cycles, then no commit may be left over
    task automatic end_test();
        repeat (4) tick();
        check(0, got_q.size());
        got_q.delete();
        $display("test %s finished with %0d errors", test_name, errors - test_errors);
    endtask

    task automatic test_reset();
        start_test("reset_state");
        check(0, commit.valid);
        check(1, empty);
        check(0, full);
        fetch.pc        = 32'h100;            // Bubble word with a PC
        fetch.reg_write = 1'b1;
        repeat (3) tick();
        fetch = '0;
        check(1, empty);
        end_test();
    endtask

    task automatic test_ooo();
        logic [XLEN-1:0] vals [4];
        start_test("ooo_complete");
        for (int i = 0; i < 4; i++) begin
            vals[i] = lcg_next();
            alloc(32'h200 + 4 * i, 5'(3 + i), i % 2 == 1);
        end
        check(0, empty);
        for (int i = 3; i >= 0; i--) complete(i % 3, 32'h200 + 4 * i, vals[i]);
        for (int i = 0; i < 4; i++) wait_commit(vals[i], 5'(3 + i), i % 2 == 1);
        check(1, empty);
        end_test();
    endtask

    task automatic test_same_cycle();
        logic [XLEN-1:0] v [4];
        logic [XLEN-1:0] v_mul;
        start_test("same_cycle");
        for (int i = 0; i < 4; i++) begin
            v[i] = lcg_next();
            alloc(32'h300 + 4 * i, 5'(10 + i), 1'b1);
        end
        v_mul  = lcg_next();
        alu_wb = '{done: 1'b1, pc: 32'h300, value: v[0]};  // Three slots at once
        mul_wb = '{done: 1'b1, pc: 32'h304, value: v[1]};
        div_wb = '{done: 1'b1, pc: 32'h308, value: v[2]};
        tick();
        alu_wb = '{done: 1'b1, pc: 32'h30c, value: v[3]};  // Same PC, alu must win
        mul_wb = '{done: 1'b1, pc: 32'h30c, value: v_mul};
        div_wb = '0;
        tick();
        idle_ports();
        for (int i = 0; i < 4; i++) wait_commit(v[i], 5'(10 + i), 1'b1);
        end_test();
    endtask

    task automatic test_full();
        logic [XLEN-1:0] v [DEPTH];
        start_test("full");
        for (int i = 0; i < DEPTH; i++) begin
            v[i] = lcg_next();
            alloc(32'h400 + 4 * i, 5'(i), 1'b1);
        end
        check(1, full);
        check(0, empty);
        alloc(32'h500, 5'd31, 1'b1);          // Presented while full
        check(1, full);
        complete(0, 32'h500, lcg_next());     // Tag of the dropped word
        for (int i = DEPTH - 1; i >= 0; i--) complete(i % 3, 32'h400 + 4 * i, v[i]);
        for (int i = 0; i < DEPTH; i++) wait_commit(v[i], 5'(i), 1'b1);
        check(1, empty);
        end_test();
    endtask

    task automatic test_branch();
        logic [XLEN-1:0] v [6];
        logic [XLEN-1:0] target;
        start_test("branch");
        target = 32'h0000_2000;
        for (int i = 0; i < 6; i++) begin
            v[i] = lcg_next();
            alloc(32'h600 + 4 * i, 5'(20 + i), 1'b0);
        end
        branch = '{taken: 1'b1, pc: 32'h608, target: target};  // Third entry
        tick();
        idle_ports();
        for (int i = 3; i < 6; i++) complete(0, 32'h600 + 4 * i, v[i]);  // Killed tags
        complete(1, 32'h604, v[1]);
        complete(2, 32'h600, v[0]);
        wait_commit(v[0], 5'd20, 1'b0);
        wait_commit(v[1], 5'd21, 1'b0);
        wait_commit(target, 5'd22, 1'b0);     // Branch retires with its target
        check(1, empty);
        v[3] = lcg_next();
        v[4] = lcg_next();
        alloc(32'h700, 5'd5, 1'b1);
        alloc(32'h704, 5'd6, 1'b1);
        complete(0, 32'h704, v[4]);
        complete(0, 32'h700, v[3]);
        wait_commit(v[3], 5'd5, 1'b1);
        wait_commit(v[4], 5'd6, 1'b1);
        end_test();
    endtask

    task automatic test_flush();
        logic [XLEN-1:0] v;
        start_test("flush");
        for (int i = 0; i < 4; i++) alloc(32'h800 + 4 * i, 5'(1 + i), 1'b1);
        complete(1, 32'h804, lcg_next());     // Head stays not ready
        complete(2, 32'h808, lcg_next());
        flush = 1'b1;
        tick();
        flush = 1'b0;
        check(1, empty);
        complete(0, 32'h800, lcg_next());     // Stale tag after flush
        repeat (4) tick();
        check(0, got_q.size());
        check(1, empty);
        v = lcg_next();
        alloc(32'h900, 5'd9, 1'b0);
        complete(0, 32'h900, v);
        wait_commit(v, 5'd9, 1'b0);
        end_test();
    endtask

    initial begin
        clk    = 1'b0;
        rst    = 1'b1;
        flush  = 1'b0;
        fetch  = '0;
        errors = 0;
        checks = 0;
        idle_ports();
        repeat (8) @(posedge clk);            // Reset held 8 cycles
        #1;
        rst = 1'b0;
        test_reset();
        test_ooo();
        test_same_cycle();
        test_full();
        test_branch();
        test_flush();
        errors += i_rob_top.i_rob_ctrl.i_rob_chk_props.fails;
        $display("6 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
